// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;

    // memory-mapped output word
    localparam logic [31:0] IO_ADDR = 32'h0000_0100;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_PASS2 = 4'd6
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_JAL  = 2'd3
    } br_t;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

endpackage

// ==== verilog/fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    input  logic        dec_stall,
    input  logic        redirect,
    input  logic [31:0] target,
    output logic [31:0] pc
);

    // redirect wins over stall, both only move while running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            if (redirect) begin
                pc <= target;
            end else if (!dec_stall) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

// ==== verilog/inst_ram.sv ====
`timescale 1ns/1ps

module inst_ram #(
    parameter int IMEM_AW = 6
) (
    input  logic                clk,
    input  logic                run,
    input  logic [31:0]         pc,
    input  logic                imem_we,
    input  logic [IMEM_AW-1:0]  imem_addr,
    input  logic [31:0]         imem_wdata,
    input  logic                dec_stall,
    input  logic                redirect,
    output core_pkg::inst_t     inst
);

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    core_pkg::inst_t mem [2**IMEM_AW];

    // load port, word addressed
    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_addr] <= imem_wdata;
        end
    end

    // registered read, word appears one cycle after pc
    always_ff @(posedge clk) begin
        if (run) begin
            if (redirect) begin
                inst <= NOP;
            end else if (!dec_stall) begin
                inst <= mem[pc[IMEM_AW+1:2]];
            end
        end
    end

endmodule

// ==== verilog/decode_rf.sv ====
`timescale 1ns/1ps

module decode_rf (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  core_pkg::inst_t            inst,
    input  logic [31:0]                pc,
    input  logic                       redirect,
    input  logic [core_pkg::XLEN-1:0]  alu_fwd,
    input  logic [4:0]                 ex_rd,
    input  logic [core_pkg::XLEN-1:0]  wb_res,
    input  logic [4:0]                 wb_rd,
    input  logic                       wb_we,
    output logic [core_pkg::XLEN-1:0]  op1,
    output logic [core_pkg::XLEN-1:0]  op2,
    output logic [core_pkg::XLEN-1:0]  store_data,
    output logic [31:0]                imm,
    output core_pkg::alu_op_t          alu_op,
    output core_pkg::br_t              br,
    output logic [4:0]                 rd,
    output logic                       rd_we,
    output logic                       mem_re,
    output logic                       mem_we,
    output logic [31:0]                ex_pc,
    output logic                       ex_valid,
    output logic                       dec_stall
);

    logic [core_pkg::XLEN-1:0] rf [32];

    logic                      dec_valid;
    logic [31:0]               dec_pc;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [4:0]                d_rd;
    logic [31:0]               d_imm;
    core_pkg::alu_op_t         d_alu;
    core_pkg::br_t             d_br;
    logic                      d_rd_we;
    logic                      d_mem_re;
    logic                      d_mem_we;
    logic                      op2_imm;
    logic                      use_rs1;
    logic                      use_rs2;
    logic [core_pkg::XLEN-1:0] rs1_val;
    logic [core_pkg::XLEN-1:0] rs2_val;

    function automatic core_pkg::alu_op_t alu_from_f3(input logic [2:0] f3, input logic sub);
        core_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = sub ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b010:  op = core_pkg::ALU_SLT;
            3'b100:  op = core_pkg::ALU_XOR;
            3'b110:  op = core_pkg::ALU_OR;
            3'b111:  op = core_pkg::ALU_AND;
            default: op = core_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        rs1      = inst.r.rs1;
        rs2      = inst.r.rs2;
        d_rd     = inst.r.rd;
        d_imm    = '0;
        d_alu    = core_pkg::ALU_ADD;
        d_br     = core_pkg::BR_NONE;
        d_rd_we  = 1'b0;
        d_mem_re = 1'b0;
        d_mem_we = 1'b0;
        op2_imm  = 1'b1;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        case (inst.r.opcode)
            core_pkg::OP_LUI: begin
                d_imm   = {inst.u.imm, 12'b0};
                d_alu   = core_pkg::ALU_PASS2;
                d_rd_we = 1'b1;
            end
            core_pkg::OP_IMM: begin
                d_imm   = {{20{inst.i.imm[11]}}, inst.i.imm};
                d_alu   = alu_from_f3(inst.i.funct3, 1'b0);
                d_rd_we = 1'b1;
                use_rs1 = 1'b1;
            end
            core_pkg::OP_REG: begin
                d_alu   = alu_from_f3(inst.r.funct3, inst.r.funct7[5]);
                d_rd_we = 1'b1;
                op2_imm = 1'b0;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            core_pkg::OP_LOAD: begin
                d_imm    = {{20{inst.i.imm[11]}}, inst.i.imm};
                d_rd_we  = 1'b1;
                d_mem_re = 1'b1;
                use_rs1  = 1'b1;
            end
            core_pkg::OP_STORE: begin
                d_imm    = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
                d_mem_we = 1'b1;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            core_pkg::OP_BRANCH: begin
                d_imm   = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                           inst.b.imm10_5, inst.b.imm4_1, 1'b0};
                // funct3 bit 0 tells bne from beq
                d_br    = inst.b.funct3[0] ? core_pkg::BR_NE : core_pkg::BR_EQ;
                op2_imm = 1'b0;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            core_pkg::OP_JAL: begin
                d_imm   = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                           inst.j.imm11, inst.j.imm10_1, 1'b0};
                d_br    = core_pkg::BR_JAL;
                d_rd_we = 1'b1;
            end
            default: begin
            end
        endcase
        // writes to x0 are dropped here
        if (d_rd == 5'd0) begin
            d_rd_we = 1'b0;
        end
    end

    // ex_rd is zero unless execute holds a forwardable result
    assign rs1_val = (ex_rd != 5'd0 && ex_rd == rs1) ? alu_fwd :
                     (wb_we && wb_rd == rs1)          ? wb_res  : rf[rs1];
    assign rs2_val = (ex_rd != 5'd0 && ex_rd == rs2) ? alu_fwd :
                     (wb_we && wb_rd == rs2)          ? wb_res  : rf[rs2];

    // load in execute feeding this instruction
    assign dec_stall = dec_valid && ex_valid && mem_re && rd_we &&
                       ((use_rs1 && rd == rs1) || (use_rs2 && rd == rs2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                rf[k] <= '0;
            end
        end else if (run && wb_we) begin
            rf[wb_rd] <= wb_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            ex_valid  <= 1'b0;
            rd_we     <= 1'b0;
            mem_re    <= 1'b0;
            mem_we    <= 1'b0;
            br        <= core_pkg::BR_NONE;
        end else if (run) begin
            // bubble on stall or flush
            ex_valid <= dec_valid && !redirect && !dec_stall;
            rd_we    <= d_rd_we;
            mem_re   <= d_mem_re;
            mem_we   <= d_mem_we;
            br       <= d_br;
            if (redirect) begin
                dec_valid <= 1'b0;
            end else if (!dec_stall) begin
                dec_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            op1        <= rs1_val;
            op2        <= op2_imm ? d_imm : rs2_val;
            store_data <= rs2_val;
            imm        <= d_imm;
            alu_op     <= d_alu;
            rd         <= d_rd;
            ex_pc      <= dec_pc;
            // follows the fetched word in inst_ram
            if (!dec_stall) begin
                dec_pc <= pc;
            end
        end
    end

endmodule

// ==== verilog/exec_mem.sv ====
`timescale 1ns/1ps

module exec_mem #(
    parameter int DMEM_AW = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic [core_pkg::XLEN-1:0]  op1,
    input  logic [core_pkg::XLEN-1:0]  op2,
    input  logic [core_pkg::XLEN-1:0]  store_data,
    input  logic [31:0]                imm,
    input  core_pkg::alu_op_t          alu_op,
    input  core_pkg::br_t              br,
    input  logic [4:0]                 rd,
    input  logic                       rd_we,
    input  logic                       mem_re,
    input  logic                       mem_we,
    input  logic [31:0]                ex_pc,
    input  logic                       ex_valid,
    output logic [core_pkg::XLEN-1:0]  alu_fwd,
    output logic [4:0]                 ex_rd,
    output logic [core_pkg::XLEN-1:0]  wb_res,
    output logic [4:0]                 wb_rd,
    output logic                       wb_we,
    output logic                       redirect,
    output logic [31:0]                target,
    output logic                       out_valid,
    output logic [core_pkg::XLEN-1:0]  out_data
);

    logic [core_pkg::XLEN-1:0] dmem [2**DMEM_AW];

    logic [core_pkg::XLEN-1:0] alu_res;
    logic [core_pkg::XLEN-1:0] result;
    logic                      taken;
    logic                      is_io;
    logic [DMEM_AW-1:0]        widx;
    logic [core_pkg::XLEN-1:0] load_q;
    logic [core_pkg::XLEN-1:0] wb_alu;
    logic                      wb_load;

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD:   alu_res = op1 + op2;
            core_pkg::ALU_SUB:   alu_res = op1 - op2;
            core_pkg::ALU_AND:   alu_res = op1 & op2;
            core_pkg::ALU_OR:    alu_res = op1 | op2;
            core_pkg::ALU_XOR:   alu_res = op1 ^ op2;
            core_pkg::ALU_SLT:   alu_res = {31'b0, $signed(op1) < $signed(op2)};
            core_pkg::ALU_PASS2: alu_res = op2;
            default:             alu_res = op1 + op2;
        endcase
    end

    always_comb begin
        case (br)
            core_pkg::BR_EQ:  taken = (op1 == op2);
            core_pkg::BR_NE:  taken = (op1 != op2);
            core_pkg::BR_JAL: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // jal links pc+4
    assign result  = (br == core_pkg::BR_JAL) ? ex_pc + 32'd4 : alu_res;
    assign alu_fwd = result;

    // loads are not forwarded from here, their data comes a cycle later
    assign ex_rd = (ex_valid && rd_we && !mem_re) ? rd : 5'd0;

    assign redirect = run && ex_valid && taken;
    assign target   = ex_pc + imm;

    // address is op1 + imm through the adder
    assign is_io = (alu_res == core_pkg::IO_ADDR);
    assign widx  = alu_res[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (run) begin
            if (ex_valid && mem_we && !is_io) begin
                dmem[widx] <= store_data;
            end
            load_q <= dmem[widx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we     <= 1'b0;
            wb_load   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= run && ex_valid && mem_we && is_io;
            if (run) begin
                wb_we   <= ex_valid && rd_we;
                wb_load <= mem_re;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            wb_rd  <= rd;
            wb_alu <= result;
            if (ex_valid && mem_we && is_io) begin
                out_data <= store_data;
            end
        end
    end

    // load data straight from the ram register
    assign wb_res = wb_load ? load_q : wb_alu;

endmodule

// ==== verilog/tiny_core.sv ====
`timescale 1ns/1ps

module tiny_core #(
    parameter int IMEM_AW = 6,
    parameter int DMEM_AW = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       imem_we,
    input  logic [IMEM_AW-1:0]         imem_addr,
    input  logic [31:0]                imem_wdata,
    output logic                       out_valid,
    output logic [core_pkg::XLEN-1:0]  out_data,
    output logic [31:0]                pc_dbg
);

    core_pkg::inst_t           inst;
    logic                      dec_stall;
    logic                      redirect;
    logic [31:0]               target;

    // decode to execute
    logic [core_pkg::XLEN-1:0] op1;
    logic [core_pkg::XLEN-1:0] op2;
    logic [core_pkg::XLEN-1:0] store_data;
    logic [31:0]               imm;
    core_pkg::alu_op_t         alu_op;
    core_pkg::br_t             br;
    logic [4:0]                rd;
    logic                      rd_we;
    logic                      mem_re;
    logic                      mem_we;
    logic [31:0]               ex_pc;
    logic                      ex_valid;

    // execute back to decode
    logic [core_pkg::XLEN-1:0] alu_fwd;
    logic [4:0]                ex_rd;
    logic [core_pkg::XLEN-1:0] wb_res;
    logic [4:0]                wb_rd;
    logic                      wb_we;

    // pc_dbg is the fetch pc itself
    fetch_pc u_fetch_pc (
        .clk, .rst_n, .run, .dec_stall, .redirect, .target,
        .pc(pc_dbg)
    );

    inst_ram #(.IMEM_AW(IMEM_AW)) u_inst_ram (
        .clk, .run, .pc(pc_dbg), .imem_we, .imem_addr, .imem_wdata,
        .dec_stall, .redirect, .inst
    );

    decode_rf u_decode_rf (
        .clk, .rst_n, .run, .inst, .pc(pc_dbg), .redirect,
        .alu_fwd, .ex_rd, .wb_res, .wb_rd, .wb_we,
        .op1, .op2, .store_data, .imm, .alu_op, .br, .rd, .rd_we,
        .mem_re, .mem_we, .ex_pc, .ex_valid, .dec_stall
    );

    exec_mem #(.DMEM_AW(DMEM_AW)) u_exec_mem (
        .clk, .rst_n, .run, .op1, .op2, .store_data, .imm, .alu_op, .br,
        .rd, .rd_we, .mem_re, .mem_we, .ex_pc, .ex_valid,
        .alu_fwd, .ex_rd, .wb_res, .wb_rd, .wb_we, .redirect, .target,
        .out_valid, .out_data
    );

endmodule

// ==== dv/tb_tiny_core.sv ====
`timescale 1ns/1ps

module tb_tiny_core;

    localparam int IMEM_AW = 6;
    localparam int DMEM_AW = 6;
    // offset of the output word from x0
    localparam logic [11:0] IO_OFF = 12'h100;
    // value that only wrong-path stores ever send
    localparam logic [11:0] MARKER = 12'h7ee;

    logic               clk;
    logic               rst_n;
    logic               run;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [31:0]        imem_wdata;
    logic               out_valid;
    logic [31:0]        out_data;
    logic [31:0]        pc_dbg;

    integer      seed = 4;
    logic [31:0] prog [$];
    logic [31:0] exp_q [$];

    tiny_core #(
        .IMEM_AW(IMEM_AW),
        .DMEM_AW(DMEM_AW)
    ) DUT (
        .clk, .rst_n, .run, .imem_we, .imem_addr, .imem_wdata,
        .out_valid, .out_data, .pc_dbg
    );

    always #2 clk = ~clk;

    // RV32I encodings
    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] reg_alu(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        if (got !== expected) begin
            fail_now($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                               $time, name, got, expected));
        end
    endtask

    // store of rs to the output word and the value it must show
    task automatic store_out(input logic [4:0] rs, input logic [31:0] value);
        prog.push_back(store_word(rs, 5'd0, IO_OFF));
        exp_q.push_back(value);
    endtask

    // x9 holds the marker in the branch and jump programs
    task automatic store_marker();
        prog.push_back(store_word(5'd9, 5'd0, IO_OFF));
    endtask

    task automatic load_prog();
        run = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = IMEM_AW'(i);
            imem_wdata = prog[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic start_prog();
        load_prog();
        apply_reset();
        run = 1'b1;
    endtask

    task automatic run_until_out(input logic [31:0] expected, input string name);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 200 && !seen; n++) begin
            @(posedge clk);
            #1;
            seen = out_valid;
        end
        if (!seen) begin
            fail_now($sformatf("no out_valid within 200 cycles while waiting for %s", name));
        end
        check_eq(name, out_data, expected);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            #1;
            check_eq("out_valid", {31'b0, out_valid}, 32'd0);
        end
    endtask

    task automatic drain_outputs(input string name);
        for (int k = 0; k < exp_q.size(); k++) begin
            run_until_out(exp_q[k], $sformatf("%s out_data[%0d]", name, k));
        end
        expect_quiet(24);
    endtask

    // back to back ops with every result forwarded into the next store
    task automatic alu_ops();
        logic [31:0] r;
        logic [11:0] a;
        logic [11:0] b;
        logic [19:0] u;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x8;
        prog.delete();
        exp_q.delete();
        r = $random(seed);
        a = r[11:0];
        r = $random(seed);
        b = r[11:0];
        r = $random(seed);
        u = r[19:0];
        x1 = sext12(a);
        x2 = x1 + sext12(b);
        x8 = {u, 12'b0};
        prog.push_back(addi(5'd1, 5'd0, a));
        prog.push_back(addi(5'd2, 5'd1, b));
        store_out(5'd2, x2);
        prog.push_back(reg_alu(7'b0100000, 3'b000, 5'd3, 5'd2, 5'd1));
        store_out(5'd3, x2 - x1);
        prog.push_back(reg_alu(7'b0000000, 3'b111, 5'd4, 5'd1, 5'd2));
        store_out(5'd4, x1 & x2);
        prog.push_back(reg_alu(7'b0000000, 3'b110, 5'd5, 5'd1, 5'd2));
        store_out(5'd5, x1 | x2);
        prog.push_back(reg_alu(7'b0000000, 3'b100, 5'd6, 5'd1, 5'd2));
        store_out(5'd6, x1 ^ x2);
        prog.push_back(reg_alu(7'b0000000, 3'b010, 5'd7, 5'd1, 5'd2));
        store_out(5'd7, ($signed(x1) < $signed(x2)) ? 32'd1 : 32'd0);
        prog.push_back(lui(5'd8, u));
        prog.push_back(reg_alu(7'b0000000, 3'b000, 5'd9, 5'd8, 5'd1));
        store_out(5'd8, x8);
        store_out(5'd9, x8 + x1);
        prog.push_back(jump_link(5'd0, 21'd0));
        start_prog();
        drain_outputs("alu");
    endtask

    task automatic load_use();
        logic [31:0] r;
        logic [11:0] v;
        logic [11:0] k;
        prog.delete();
        exp_q.delete();
        r = $random(seed);
        v = r[11:0];
        r = $random(seed);
        k = r[11:0];
        prog.push_back(addi(5'd1, 5'd0, v));
        prog.push_back(store_word(5'd1, 5'd0, 12'h020));
        prog.push_back(load_word(5'd2, 5'd0, 12'h020));
        // uses x2 right after the load
        prog.push_back(addi(5'd3, 5'd2, k));
        store_out(5'd3, sext12(v) + sext12(k));
        prog.push_back(load_word(5'd4, 5'd0, 12'h020));
        store_out(5'd4, sext12(v));
        prog.push_back(jump_link(5'd0, 21'd0));
        start_prog();
        drain_outputs("load");
    endtask

    task automatic branch_paths();
        prog.delete();
        exp_q.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd9, 5'd0, MARKER));
        prog.push_back(addi(5'd3, 5'd0, 12'd7));
        prog.push_back(addi(5'd4, 5'd0, 12'd11));
        prog.push_back(addi(5'd2, 5'd0, 12'd5));
        // beq taken over two marker stores
        prog.push_back(branch(3'b000, 5'd1, 5'd2, 13'd12));
        store_marker();
        store_marker();
        store_out(5'd1, 32'd5);
        // beq not taken
        prog.push_back(branch(3'b000, 5'd1, 5'd3, 13'd8));
        store_out(5'd3, 32'd7);
        // bne taken
        prog.push_back(branch(3'b001, 5'd1, 5'd3, 13'd12));
        store_marker();
        store_marker();
        store_out(5'd4, 32'd11);
        // bne not taken
        prog.push_back(branch(3'b001, 5'd1, 5'd2, 13'd8));
        store_out(5'd2, 32'd5);
        prog.push_back(jump_link(5'd0, 21'd0));
        start_prog();
        drain_outputs("branch");
    endtask

    task automatic jal_link();
        logic [31:0] jal_pc;
        prog.delete();
        exp_q.delete();
        prog.push_back(addi(5'd9, 5'd0, MARKER));
        prog.push_back(addi(5'd1, 5'd0, 12'd1));
        jal_pc = prog.size() * 4;
        prog.push_back(jump_link(5'd5, 21'd12));
        store_marker();
        store_marker();
        store_out(5'd5, jal_pc + 32'd4);
        prog.push_back(reg_alu(7'b0000000, 3'b000, 5'd6, 5'd5, 5'd1));
        store_out(5'd6, jal_pc + 32'd5);
        prog.push_back(jump_link(5'd0, 21'd0));
        start_prog();
        drain_outputs("jal");
    endtask

    // run dropped while the third store sits in execute
    task automatic run_pause();
        logic [31:0] r;
        logic [11:0] imm;
        logic [31:0] acc;
        logic [31:0] held_pc;
        prog.delete();
        exp_q.delete();
        acc = 32'd0;
        for (int k = 0; k < 6; k++) begin
            r = $random(seed);
            imm = r[11:0];
            acc = acc + sext12(imm);
            prog.push_back(addi(5'd1, 5'd1, imm));
            store_out(5'd1, acc);
        end
        prog.push_back(jump_link(5'd0, 21'd0));
        start_prog();
        run_until_out(exp_q[0], "pause out_data[0]");
        run_until_out(exp_q[1], "pause out_data[1]");
        @(posedge clk);
        #1;
        run = 1'b0;
        held_pc = pc_dbg;
        for (int n = 0; n < 12; n++) begin
            @(posedge clk);
            #1;
            check_eq("pc_dbg", pc_dbg, held_pc);
            check_eq("out_valid", {31'b0, out_valid}, 32'd0);
        end
        run = 1'b1;
        for (int k = 2; k < exp_q.size(); k++) begin
            run_until_out(exp_q[k], $sformatf("pause out_data[%0d]", k));
        end
        expect_quiet(24);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        alu_ops();
        load_use();
        branch_paths();
        jal_link();
        run_pause();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tiny_core.f ====
verilog/core_pkg.sv
verilog/fetch_pc.sv
verilog/inst_ram.sv
verilog/decode_rf.sv
verilog/exec_mem.sv
verilog/tiny_core.sv
dv/tb_tiny_core.sv

// ==== Makefile ====
TOP := tb_tiny_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f tiny_core.f

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) \
		-f tiny_core.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
